// ==== Bender.yml ====
package:
  name: flash_subsys

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/flash_pkg.sv
      - verilog/spi_flash_reader.sv
      - verilog/bus_arb.sv
      - verilog/flash_dbus_bridge.sv
      - verilog/gpio_regs.sv
      - verilog/flash_subsys.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tests/spi_flash_model.sv
      - tests/tb_flash_subsys.sv

// ==== flist.f ====
+incdir+verilog
verilog/flash_pkg.sv
verilog/spi_flash_reader.sv
verilog/bus_arb.sv
verilog/flash_dbus_bridge.sv
verilog/gpio_regs.sv
verilog/flash_subsys.sv
tests/spi_flash_model.sv
tests/tb_flash_subsys.sv

// ==== tests/spi_flash_model.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "flash_params.svh"

module spi_flash_model (
    input  wire  i_cs,
    input  wire  i_sck,
    input  wire  i_mosi,
    output logic o_miso,
    output logic o_cmd_err
);

    // Command and address bits, newest at the bottom
    logic [31:0] rx_bits;
    // Read data, first byte in the top bits
    logic [31:0] tx_bits;
    int bit_cnt;

    initial begin
        rx_bits = '0;
        tx_bits = '0;
        bit_cnt = 0;
        o_miso = 1'b0;
        o_cmd_err = 1'b0;
    end

    // Flash contents follow the address
    function automatic logic [7:0] mem_byte(input logic [23:0] adr);
        return adr[7:0] ^ 8'ha5;
    endfunction

    always @(posedge i_cs) begin
        bit_cnt = 0;
    end

    // Mode 0, sample MOSI on the rising clock
    always @(posedge i_sck) begin
        if (!i_cs) begin
            if (bit_cnt < 32) begin
                rx_bits = {rx_bits[30:0], i_mosi};
            end
            bit_cnt = bit_cnt + 1;
            if (bit_cnt == 8 && rx_bits[7:0] != `SPI_READ_CMD) begin
                o_cmd_err <= 1'b1;
            end
            if (bit_cnt == 8 + `FLASH_ADR_BITS) begin
                tx_bits = {mem_byte(rx_bits[23:0]), mem_byte(rx_bits[23:0] + 24'd1),
                           mem_byte(rx_bits[23:0] + 24'd2), mem_byte(rx_bits[23:0] + 24'd3)};
            end
        end
    end

    // Next data bit goes out on the falling clock
    always @(negedge i_sck) begin
        if (!i_cs && bit_cnt >= 32 && bit_cnt < 64) begin
            o_miso <= tx_bits[63 - bit_cnt];
        end
    end

endmodule

`default_nettype wire

// ==== tests/tb_flash_subsys.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "flash_params.svh"

module tb_flash_subsys
    import flash_pkg::*;
();

    logic ck;
    logic RESET_LOOP;
    logic ibus_cyc;
    wb_adr_t ibus_adr;
    logic ibus_ack;
    wb_dat_t ibus_rdt;
    logic dbus_cyc;
    logic dbus_we;
    wb_adr_t dbus_adr;
    wb_dat_t dbus_dat;
    wb_sel_t dbus_sel;
    logic dbus_ack;
    wb_dat_t dbus_rdt;
    gpio_t gpio;
    logic spi_cs;
    logic spi_sck;
    logic spi_mosi;
    logic spi_miso;
    logic cmd_err;
    integer seed;

    flash_subsys flash_subsys_inst (
        .ck(ck),
        .RESET_LOOP(RESET_LOOP),
        .i_ibus_cyc(ibus_cyc),
        .i_ibus_adr(ibus_adr),
        .o_ibus_ack(ibus_ack),
        .o_ibus_rdt(ibus_rdt),
        .i_dbus_cyc(dbus_cyc),
        .i_dbus_we(dbus_we),
        .i_dbus_adr(dbus_adr),
        .i_dbus_dat(dbus_dat),
        .i_dbus_sel(dbus_sel),
        .o_dbus_ack(dbus_ack),
        .o_dbus_rdt(dbus_rdt),
        .o_gpio(gpio),
        .o_spi_cs(spi_cs),
        .o_spi_sck(spi_sck),
        .o_spi_mosi(spi_mosi),
        .i_spi_miso(spi_miso)
    );

    spi_flash_model u_flash_model (
        .i_cs(spi_cs),
        .i_sck(spi_sck),
        .i_mosi(spi_mosi),
        .o_miso(spi_miso),
        .o_cmd_err(cmd_err)
    );

    initial begin
        ck = 1'b0;
        forever #20 ck = ~ck;
    end

    // Byte at address a is a[7:0] ^ a5 and the lowest address lands in bits 7:0
    function automatic wb_dat_t flash_word(input wb_adr_t adr);
        wb_dat_t word;
        logic [7:0] base;
        base = {adr[7:2], 2'b00};
        for (int i = 0; i < 4; i++) begin
            word[8*i +: 8] = (base + 8'(i)) ^ 8'ha5;
        end
        return word;
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(input string name, input wb_dat_t exp, input wb_dat_t act);
        if (act !== exp) begin
            abort_run($sformatf("ERROR %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_gpio(input string name, input gpio_t exp, input gpio_t act);
        if (act !== exp) begin
            abort_run($sformatf("ERROR %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("ERROR %s expected %b actual %b", name, exp, act));
        end
    endtask

    task automatic ibus_read(input wb_adr_t adr, output wb_dat_t dat);
        int waited;
        waited = 0;
        @(posedge ck);
        #2;
        ibus_cyc = 1'b1;
        ibus_adr = adr;
        do begin
            @(posedge ck);
            #2;
            waited++;
            if (waited > 1000) begin
                abort_run("Timeout waiting for the instruction bus ack");
            end
        end while (!ibus_ack);
        dat = ibus_rdt;
        // Release cyc after the edge that samples ack
        @(posedge ck);
        #2;
        ibus_cyc = 1'b0;
    endtask

    task automatic dbus_access(input logic we, input wb_adr_t adr, input wb_dat_t dat,
                               input wb_sel_t sel, output wb_dat_t rdt);
        int waited;
        waited = 0;
        @(posedge ck);
        #2;
        dbus_cyc = 1'b1;
        dbus_we = we;
        dbus_adr = adr;
        dbus_dat = dat;
        dbus_sel = sel;
        do begin
            @(posedge ck);
            #2;
            waited++;
            if (waited > 1000) begin
                abort_run("Timeout waiting for the data bus ack");
            end
        end while (!dbus_ack);
        rdt = dbus_rdt;
        @(posedge ck);
        #2;
        dbus_cyc = 1'b0;
        dbus_we = 1'b0;
    endtask

    // Unmapped devices must stay silent
    task automatic probe_unmapped(input wb_adr_t adr);
        @(posedge ck);
        #2;
        dbus_cyc = 1'b1;
        dbus_we = 1'b0;
        dbus_adr = adr;
        dbus_sel = 4'hf;
        repeat (300) begin
            @(posedge ck);
            #2;
            if (dbus_ack) begin
                abort_run("An unmapped data bus address was acknowledged");
            end
        end
        dbus_cyc = 1'b0;
    endtask

    always @(posedge cmd_err) begin
        abort_run("The flash model received a command other than the read command");
    end

    initial begin
        wb_dat_t rd;
        wb_dat_t rd2;
        wb_adr_t adr;
        time t_ibus;
        time t_dbus;
        seed = 32'hdae8;
        RESET_LOOP = 1'b1;
        ibus_cyc = 1'b0;
        ibus_adr = '0;
        dbus_cyc = 1'b0;
        dbus_we = 1'b0;
        dbus_adr = '0;
        dbus_dat = '0;
        dbus_sel = '0;
        repeat (2) @(posedge ck);
        #2;
        RESET_LOOP = 1'b0;

        check_bit("reset spi_cs", 1'b1, spi_cs);
        check_bit("reset spi_sck", 1'b0, spi_sck);
        check_bit("reset ibus_ack", 1'b0, ibus_ack);
        check_bit("reset dbus_ack", 1'b0, dbus_ack);
        check_gpio("reset gpio", 8'h00, gpio);

        ibus_read(32'h0000_0000, rd);
        check_word("ibus fixed 0", flash_word(32'h0000_0000), rd);
        ibus_read(32'h0012_3458, rd);
        check_word("ibus fixed 123458", flash_word(32'h0012_3458), rd);
        repeat (4) begin
            adr = $random(seed) & 32'h00ff_fffc;
            ibus_read(adr, rd);
            check_word($sformatf("ibus random %h", adr), flash_word(adr), rd);
        end

        adr = {`FLASH_DEV, 24'h00_0104};
        dbus_access(1'b0, adr, '0, 4'hf, rd);
        check_word("dbus flash read", flash_word({8'h00, adr[23:0]}), rd);
        dbus_access(1'b1, adr, 32'hdead_beef, 4'hf, rd);
        dbus_access(1'b0, adr, '0, 4'hf, rd);
        check_word("dbus flash after write", flash_word({8'h00, adr[23:0]}), rd);
        adr = {`FLASH_DEV, 24'($random(seed)) & 24'hff_fffc};
        dbus_access(1'b0, adr, '0, 4'hf, rd);
        check_word("dbus flash random", flash_word({8'h00, adr[23:0]}), rd);

        adr = {`GPIO_DEV, 24'h00_0000};
        dbus_access(1'b1, adr, 32'h1234_565a, 4'b0001, rd);
        check_gpio("gpio write", 8'h5a, gpio);
        dbus_access(1'b0, adr, '0, 4'hf, rd);
        check_word("gpio read", 32'h0000_005a, rd);
        dbus_access(1'b1, adr, 32'h0000_00c3, 4'b1110, rd);
        check_gpio("gpio write without lane 0", 8'h5a, gpio);

        // Both masters ask in the same cycle
        fork
            begin
                ibus_read(32'h0000_0200, rd);
                t_ibus = $time;
            end
            begin
                dbus_access(1'b0, {`FLASH_DEV, 24'h00_0300}, '0, 4'hf, rd2);
                t_dbus = $time;
            end
        join
        if (t_ibus >= t_dbus) begin
            abort_run("The data bus was served before the instruction bus");
        end
        check_word("tie ibus", flash_word(32'h0000_0200), rd);
        check_word("tie dbus", flash_word(32'h0000_0300), rd2);

        probe_unmapped(32'h2000_0010);
        dbus_access(1'b0, {`GPIO_DEV, 24'h00_0000}, '0, 4'hf, rd);
        check_word("gpio read after unmapped", 32'h0000_005a, rd);

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/bus_arb.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_arb
    import flash_pkg::*;
(
    input  wire          ck,
    input  wire          RESET_LOOP,
    // Master A, high priority
    input  wire          i_a_cyc,
    input  wire wb_adr_t i_a_adr,
    output logic         o_a_ack,
    output wb_dat_t      o_a_rdt,
    // Master B, low priority
    input  wire          i_b_cyc,
    input  wire wb_adr_t i_b_adr,
    output logic         o_b_ack,
    output wb_dat_t      o_b_rdt,
    // Shared slave
    output logic         o_x_cyc,
    output wb_adr_t      o_x_adr,
    input  wire          i_x_ack,
    input  wire wb_dat_t i_x_rdt
);

    logic busy;
    logic owner_b;
    logic grant_a;
    logic grant_b;

    // Grant only when idle, A wins a tie
    always_ff @(posedge ck) begin
        if (RESET_LOOP) begin
            busy <= 1'b0;
            owner_b <= 1'b0;
        end else if (!busy) begin
            if (i_a_cyc) begin
                busy <= 1'b1;
                owner_b <= 1'b0;
            end else if (i_b_cyc) begin
                busy <= 1'b1;
                owner_b <= 1'b1;
            end
        end else if (i_x_ack) begin
            // Release once the ack has gone back
            busy <= 1'b0;
        end
    end

    assign grant_a = busy && !owner_b;
    assign grant_b = busy && owner_b;

    assign o_x_cyc = (grant_a && i_a_cyc) || (grant_b && i_b_cyc);
    assign o_x_adr = owner_b ? i_b_adr : i_a_adr;

    // Only the owner sees a response
    assign o_a_ack = grant_a && i_x_ack;
    assign o_a_rdt = grant_a ? i_x_rdt : '0;
    assign o_b_ack = grant_b && i_x_ack;
    assign o_b_rdt = grant_b ? i_x_rdt : '0;

endmodule

`default_nettype wire

// ==== verilog/flash_dbus_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "flash_params.svh"

module flash_dbus_bridge
    import flash_pkg::*;
(
    input  wire          ck,
    input  wire          RESET_LOOP,
    // Data bus slave side
    input  wire          i_dbus_cyc,
    input  wire          i_dbus_we,
    input  wire wb_adr_t i_dbus_adr,
    output logic         o_dbus_ack,
    output wb_dat_t      o_dbus_rdt,
    // Master side towards the arbiter
    output logic         o_fl_cyc,
    output wb_adr_t      o_fl_adr,
    input  wire          i_fl_ack,
    input  wire wb_dat_t i_fl_rdt
);

    logic hit;
    logic wr_ack;
    logic acked;

    assign hit = i_dbus_cyc && (i_dbus_adr[31:24] == `FLASH_DEV);

    // Reads go to the flash reader
    assign o_fl_cyc = hit && !i_dbus_we && !acked;
    assign o_fl_adr = wb_adr_t'(i_dbus_adr[`FLASH_ADR_BITS-1:0]);

    always_ff @(posedge ck) begin
        if (RESET_LOOP) begin
            wr_ack <= 1'b0;
            acked <= 1'b0;
        end else begin
            // Writes are dropped, one ack only
            wr_ack <= hit && i_dbus_we && !wr_ack && !acked;
            // Set by an ack, cleared when cyc falls
            acked <= i_dbus_cyc && (acked || o_dbus_ack);
        end
    end

    assign o_dbus_ack = wr_ack || i_fl_ack;
    assign o_dbus_rdt = i_fl_ack ? i_fl_rdt : '0;

endmodule

`default_nettype wire

// ==== verilog/flash_params.svh ====
`ifndef FLASH_PARAMS_SVH
`define FLASH_PARAMS_SVH

// Device select values, data bus address bits 31:24
`define FLASH_DEV 8'h70
`define GPIO_DEV 8'h40

// SPI flash read command
`define SPI_READ_CMD 8'h03

// Address bits sent to the flash after the command
`define FLASH_ADR_BITS 24

`endif

// ==== verilog/flash_pkg.sv ====
`default_nettype none

package flash_pkg;

    // Wishbone byte address
    typedef logic [31:0] wb_adr_t;

    // Wishbone data word
    typedef logic [31:0] wb_dat_t;

    // One select bit per byte lane
    typedef logic [3:0] wb_sel_t;

    // GPIO output register
    typedef logic [7:0] gpio_t;

endpackage

`default_nettype wire

// ==== verilog/flash_subsys.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "flash_params.svh"

module flash_subsys
    import flash_pkg::*;
(
    input  wire          ck,
    input  wire          RESET_LOOP,
    // Instruction fetch bus
    input  wire          i_ibus_cyc,
    input  wire wb_adr_t i_ibus_adr,
    output logic         o_ibus_ack,
    output wb_dat_t      o_ibus_rdt,
    // Data bus
    input  wire          i_dbus_cyc,
    input  wire          i_dbus_we,
    input  wire wb_adr_t i_dbus_adr,
    input  wire wb_dat_t i_dbus_dat,
    input  wire wb_sel_t i_dbus_sel,
    output logic         o_dbus_ack,
    output wb_dat_t      o_dbus_rdt,
    // GPIO and SPI pins
    output gpio_t        o_gpio,
    output logic         o_spi_cs,
    output logic         o_spi_sck,
    output logic         o_spi_mosi,
    input  wire          i_spi_miso
);

    // Bridge to arbiter
    logic fl_cyc;
    wb_adr_t fl_adr;
    logic fl_ack;
    wb_dat_t fl_rdt;

    // Arbiter to reader
    logic x_cyc;
    wb_adr_t x_adr;
    logic x_ack;
    wb_dat_t x_rdt;

    // Data bus slave responses
    logic flash_ack;
    wb_dat_t flash_rdt;
    logic gpio_ack;
    wb_dat_t gpio_rdt;

    flash_dbus_bridge u_bridge (
        .ck(ck),
        .RESET_LOOP(RESET_LOOP),
        .i_dbus_cyc(i_dbus_cyc),
        .i_dbus_we(i_dbus_we),
        .i_dbus_adr(i_dbus_adr),
        .o_dbus_ack(flash_ack),
        .o_dbus_rdt(flash_rdt),
        .o_fl_cyc(fl_cyc),
        .o_fl_adr(fl_adr),
        .i_fl_ack(fl_ack),
        .i_fl_rdt(fl_rdt)
    );

    gpio_regs u_gpio (
        .ck(ck),
        .RESET_LOOP(RESET_LOOP),
        .i_dbus_cyc(i_dbus_cyc),
        .i_dbus_we(i_dbus_we),
        .i_dbus_adr(i_dbus_adr),
        .i_dbus_dat(i_dbus_dat),
        .i_dbus_sel(i_dbus_sel),
        .o_dbus_ack(gpio_ack),
        .o_dbus_rdt(gpio_rdt),
        .o_gpio(o_gpio)
    );

    // Instruction fetch has priority over the flash window
    bus_arb u_arb (
        .ck(ck),
        .RESET_LOOP(RESET_LOOP),
        .i_a_cyc(i_ibus_cyc),
        .i_a_adr(i_ibus_adr),
        .o_a_ack(o_ibus_ack),
        .o_a_rdt(o_ibus_rdt),
        .i_b_cyc(fl_cyc),
        .i_b_adr(fl_adr),
        .o_b_ack(fl_ack),
        .o_b_rdt(fl_rdt),
        .o_x_cyc(x_cyc),
        .o_x_adr(x_adr),
        .i_x_ack(x_ack),
        .i_x_rdt(x_rdt)
    );

    spi_flash_reader u_reader (
        .ck(ck),
        .RESET_LOOP(RESET_LOOP),
        .i_cyc(x_cyc),
        .i_adr(x_adr),
        .o_rdt(x_rdt),
        .o_ack(x_ack),
        .o_spi_cs(o_spi_cs),
        .o_spi_sck(o_spi_sck),
        .o_spi_mosi(o_spi_mosi),
        .i_spi_miso(i_spi_miso)
    );

    // Idle slaves drive zero, unmapped addresses never ack
    assign o_dbus_ack = flash_ack | gpio_ack;
    assign o_dbus_rdt = flash_rdt | gpio_rdt;

endmodule

`default_nettype wire

// ==== verilog/gpio_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "flash_params.svh"

module gpio_regs
    import flash_pkg::*;
(
    input  wire          ck,
    input  wire          RESET_LOOP,
    input  wire          i_dbus_cyc,
    input  wire          i_dbus_we,
    input  wire wb_adr_t i_dbus_adr,
    input  wire wb_dat_t i_dbus_dat,
    input  wire wb_sel_t i_dbus_sel,
    output logic         o_dbus_ack,
    output wb_dat_t      o_dbus_rdt,
    output gpio_t        o_gpio
);

    logic hit;
    logic wr_en;

    assign hit = i_dbus_cyc && (i_dbus_adr[31:24] == `GPIO_DEV);

    // Byte lane 0 only
    assign wr_en = hit && !o_dbus_ack && i_dbus_we && i_dbus_sel[0];

    always_ff @(posedge ck) begin
        if (RESET_LOOP) begin
            o_dbus_ack <= 1'b0;
            o_gpio <= '0;
        end else begin
            o_dbus_ack <= hit && !o_dbus_ack;
            if (wr_en) begin
                o_gpio <= i_dbus_dat[$bits(gpio_t)-1:0];
            end
        end
    end

    // Zero unless acking a read, safe to OR on the bus
    assign o_dbus_rdt = (o_dbus_ack && !i_dbus_we) ? wb_dat_t'(o_gpio) : '0;

endmodule

`default_nettype wire

// ==== verilog/spi_flash_reader.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "flash_params.svh"

module spi_flash_reader
    import flash_pkg::*;
(
    input  wire          ck,
    input  wire          RESET_LOOP,
    input  wire          i_cyc,
    input  wire wb_adr_t i_adr,
    output wb_dat_t      o_rdt,
    output logic         o_ack,
    output logic         o_spi_cs,
    output logic         o_spi_sck,
    output logic         o_spi_mosi,
    input  wire          i_spi_miso
);

    // Command plus address, then one data word
    localparam int OUT_BITS = 8 + `FLASH_ADR_BITS;
    localparam int XFER_BITS = OUT_BITS + $bits(wb_dat_t);
    localparam int CW = $clog2(XFER_BITS);
    localparam logic [CW-1:0] LAST_OUT = CW'(OUT_BITS - 1);
    localparam logic [CW-1:0] LAST_IN = CW'(XFER_BITS - 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_OUT,
        ST_IN,
        ST_DONE
    } state_t;

    state_t state;
    logic [CW-1:0] bit_cnt;
    wb_dat_t sreg;
    wb_dat_t rx_word;
    logic start;

    // New request, but not the one just acknowledged
    assign start = (state == ST_IDLE) && i_cyc && !o_ack;

    always_ff @(posedge ck) begin
        if (RESET_LOOP) begin
            state <= ST_IDLE;
            bit_cnt <= '0;
            o_spi_cs <= 1'b1;
            o_spi_sck <= 1'b0;
            o_ack <= 1'b0;
        end else begin
            o_ack <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        bit_cnt <= '0;
                        o_spi_cs <= 1'b0;
                        state <= ST_OUT;
                    end
                end
                ST_OUT, ST_IN: begin
                    // Mode 0, SCK toggles every clock
                    o_spi_sck <= !o_spi_sck;
                    if (o_spi_sck) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == LAST_OUT) begin
                            state <= ST_IN;
                        end
                        if (bit_cnt == LAST_IN) begin
                            state <= ST_DONE;
                        end
                    end
                end
                ST_DONE: begin
                    o_spi_cs <= 1'b1;
                    o_ack <= 1'b1;
                    state <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Shared shift register, MSB goes out first and MISO comes in at the bottom
    always_ff @(posedge ck) begin
        if (start) begin
            sreg <= {`SPI_READ_CMD, i_adr[`FLASH_ADR_BITS-1:2], 2'b00};
        end else if ((state == ST_OUT || state == ST_IN) && o_spi_sck) begin
            sreg <= {sreg[$bits(wb_dat_t)-2:0], i_spi_miso};
        end
    end

    // First byte received is the lowest address
    assign rx_word = {sreg[7:0], sreg[15:8], sreg[23:16], sreg[31:24]};

    assign o_rdt = o_ack ? rx_word : '0;

    // Hold MOSI low outside the command phase
    assign o_spi_mosi = (state == ST_OUT) && sreg[$bits(wb_dat_t)-1];

endmodule

`default_nettype wire
